// ==== all.f ====
+incdir+common
common/rab_pkg.sv
hdl/meta_fifo.sv
aw_check/aw_check.sv
w_filter/w_filter.sv
b_send/b_send.sv
hdl/rab_write_path.sv
sim/tb_clock.sv
sim/tb_rab_write_path.sv

// ==== aw_check/aw_check.sv ====
// **************************************************************************
// AW side of the RAB: region table, lookup, translation and drop decision
// one burst at a time is registered and compared against all regions in
// the following cycle; forwarded bursts leave on m_aw, and every burst
// pushes one decision into the decision FIFO
// **************************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "rab_settings.svh"

module aw_check (
  input  wire                                 axi4_aclk,
  input  wire                                 axi4_arstn,
  input  wire                                 cfg_we_i,
  input  wire  [$clog2(`RAB_NUM_REGIONS)-1:0] cfg_idx_i,
  input  wire  [`RAB_ADDR_WIDTH-1:0]          cfg_base_i,
  input  wire  [`RAB_ADDR_WIDTH-1:0]          cfg_end_i,
  input  wire  [`RAB_ADDR_WIDTH-1:0]          cfg_phys_i,
  input  wire                                 cfg_wen_i,
  input  wire  [`RAB_ID_WIDTH-1:0]            s_awid_i,
  input  wire  [`RAB_ADDR_WIDTH-1:0]          s_awaddr_i,
  input  wire  [7:0]                          s_awlen_i,
  input  wire  [`RAB_USER_WIDTH-1:0]          s_awuser_i,
  input  wire                                 s_awvalid_i,
  output logic                                s_awready_o,
  output logic [`RAB_ID_WIDTH-1:0]            m_awid_o,
  output logic [`RAB_ADDR_WIDTH-1:0]          m_awaddr_o,
  output logic [7:0]                          m_awlen_o,
  output logic                                m_awvalid_o,
  input  wire                                 m_awready_i,
  output rab_pkg::drop_meta_t                 dec_o,
  output logic                                dec_valid_o,
  input  wire                                 dec_ready_i
);

  import rab_pkg::*;

  localparam int NREG  = `RAB_NUM_REGIONS;
  localparam int IDX_W = $clog2(NREG);

  logic [`RAB_ADDR_WIDTH-1:0] reg_base [NREG];
  logic [`RAB_ADDR_WIDTH-1:0] reg_end  [NREG];
  logic [`RAB_ADDR_WIDTH-1:0] reg_phys [NREG];
  logic [NREG-1:0]            reg_wen;

  logic                       pending;
  logic [`RAB_ID_WIDTH-1:0]   aw_id_q;
  logic [`RAB_ADDR_WIDTH-1:0] aw_addr_q;
  logic [7:0]                 aw_len_q;
  logic                       aw_pref_q;

  logic                       hit;
  logic [IDX_W-1:0]           hit_idx;
  logic                       drop;

  // the table is written without a handshake and the new entry counts from the next cycle
  always_ff @(posedge axi4_aclk) begin
    if (cfg_we_i) begin
      reg_base[cfg_idx_i] <= cfg_base_i;
      reg_end[cfg_idx_i]  <= cfg_end_i;
      reg_phys[cfg_idx_i] <= cfg_phys_i;
    end
  end

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      reg_wen <= '0;
    end else if (cfg_we_i) begin
      reg_wen[cfg_idx_i] <= cfg_wen_i;
    end
  end

  always_ff @(posedge axi4_aclk) begin
    if (s_awvalid_i && s_awready_o) begin
      aw_id_q   <= s_awid_i;
      aw_addr_q <= s_awaddr_i;
      aw_len_q  <= s_awlen_i;
      aw_pref_q <= s_awuser_i[0];
    end
  end

  // walking down from the top leaves the lowest matching region in hit_idx
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = NREG - 1; i >= 0; i--) begin
      if (aw_addr_q >= reg_base[i] && aw_addr_q <= reg_end[i]) begin
        hit     = 1'b1;
        hit_idx = IDX_W'(i);
      end
    end
  end

  assign drop = aw_pref_q | ~hit | ~reg_wen[hit_idx];

  assign m_awid_o    = aw_id_q;
  assign m_awlen_o   = aw_len_q;
  assign m_awaddr_o  = aw_addr_q - reg_base[hit_idx] + reg_phys[hit_idx];
  assign m_awvalid_o = pending & ~drop;

  // a forwarded burst pushes its decision together with the m_aw transfer
  assign dec_o       = '{drop: drop, prefetch: aw_pref_q, hit: hit, id: aw_id_q};
  assign dec_valid_o = pending & (drop | m_awready_i);

  // room in the decision FIFO is checked up front, so the later push never stalls
  assign s_awready_o = ~pending & dec_ready_i;

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      pending <= 1'b0;
    end else if (s_awvalid_i && s_awready_o) begin
      pending <= 1'b1;
    end else if (dec_valid_o && dec_ready_i) begin
      pending <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== b_send/b_send.sv ====
// **************************************************************************
// B side of the RAB: slave responses and injected responses for drops
// dropped bursts queue up in a local FIFO; while one is served, the
// slave B channel is held off and the injected response is presented
// **************************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "rab_settings.svh"

module b_send (
  input  wire                        axi4_aclk,
  input  wire                        axi4_arstn,
  input  wire  rab_pkg::drop_meta_t  drop_i,
  input  wire                        drop_valid_i,
  output logic                       drop_ready_o,
  output logic [`RAB_ID_WIDTH-1:0]   s_bid_o,
  output logic [1:0]                 s_bresp_o,
  output logic [`RAB_USER_WIDTH-1:0] s_buser_o,
  output logic                       s_bvalid_o,
  input  wire                        s_bready_i,
  input  wire  [`RAB_ID_WIDTH-1:0]   m_bid_i,
  input  wire  [1:0]                 m_bresp_i,
  input  wire  [`RAB_USER_WIDTH-1:0] m_buser_i,
  input  wire                        m_bvalid_i,
  output logic                       m_bready_o
);

  import rab_pkg::*;

  drop_meta_t meta;
  logic       meta_valid;
  logic       meta_pop;
  logic       dropping;
  axi_resp_e  inj_resp;

  meta_fifo #(
    .WIDTH ($bits(drop_meta_t))
  ) u_drop_fifo (
    .axi4_aclk   (axi4_aclk),
    .axi4_arstn  (axi4_arstn),
    .in_data_i   (drop_i),
    .in_valid_i  (drop_valid_i),
    .in_ready_o  (drop_ready_o),
    .out_data_o  (meta),
    .out_valid_o (meta_valid),
    .out_ready_i (meta_pop)
  );

  assign meta_pop = dropping & s_bready_i;

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      dropping <= 1'b0;
    end else if (meta_valid && !dropping) begin
      dropping <= 1'b1;
    end else if (meta_pop) begin
      dropping <= 1'b0;
    end
  end

  // only a prefetch that found its region is answered OKAY
  assign inj_resp = (meta.prefetch && meta.hit) ? OKAY : SLVERR;

  assign s_bid_o    = dropping ? meta.id : m_bid_i;
  assign s_bresp_o  = dropping ? inj_resp : m_bresp_i;
  assign s_buser_o  = dropping ? '0 : m_buser_i;
  assign s_bvalid_o = dropping | m_bvalid_i;
  assign m_bready_o = ~dropping & s_bready_i;

endmodule

`default_nettype wire

// ==== common/rab_pkg.sv ====
// **************************************************************************
// shared types of the RAB write path
// modules import it with a wildcard in their body and use scoped names
// in their port lists
// **************************************************************************
`default_nettype none

`include "rab_settings.svh"

package rab_pkg;

  // only the two responses the RAB ever produces itself
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  // decision for one write burst, made by the AW lookup
  typedef struct packed {
    logic                     drop;
    logic                     prefetch;
    // some region matched, with or without write permission
    logic                     hit;
    logic [`RAB_ID_WIDTH-1:0] id;
  } drop_meta_t;

endpackage

`default_nettype wire

// ==== common/rab_settings.svh ====
// **************************************************************************
// global sizes of the RAB write path
// include this file wherever a width, the region count or the FIFO depth
// is needed; the package with the shared types includes it as well
// **************************************************************************
`ifndef RAB_SETTINGS_SVH
`define RAB_SETTINGS_SVH

`define RAB_ID_WIDTH     4
// bit 0 of awuser marks a prefetch
`define RAB_USER_WIDTH   2
`define RAB_ADDR_WIDTH   32
`define RAB_DATA_WIDTH   32
`define RAB_NUM_REGIONS  4
// depth of the decision FIFO and of the drop FIFO in the B sender
`define RAB_FIFO_DEPTH   4

`endif

// ==== hdl/meta_fifo.sv ====
// **************************************************************************
// small synchronous FIFO with valid/ready on both sides
// depth comes from the settings header, the word width is a parameter
// the head word is valid one cycle after its push (no fall-through)
// **************************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "rab_settings.svh"

module meta_fifo #(
  parameter int WIDTH = 8
) (
  input  wire              axi4_aclk,
  input  wire              axi4_arstn,
  input  wire  [WIDTH-1:0] in_data_i,
  input  wire              in_valid_i,
  output logic             in_ready_o,
  output logic [WIDTH-1:0] out_data_o,
  output logic             out_valid_o,
  input  wire              out_ready_i
);

  localparam int DEPTH = `RAB_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready_o  = (count != CNT_W'(DEPTH));
  assign out_valid_o = (count != '0);
  assign out_data_o  = mem[rd_ptr];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  always_ff @(posedge axi4_aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_data_i;
    end
  end

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // a push into a full FIFO cannot happen, so push and pop together keep the count
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rab_write_path.sv ====
// **************************************************************************
// top of the RAB write path
// joins the AW check, the decision FIFO, the W filter and the B sender;
// the s side faces the AXI master, the m side faces memory
// **************************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "rab_settings.svh"

module rab_write_path (
  input  wire                                 axi4_aclk,
  input  wire                                 axi4_arstn,
  input  wire                                 cfg_we_i,
  input  wire  [$clog2(`RAB_NUM_REGIONS)-1:0] cfg_idx_i,
  input  wire  [`RAB_ADDR_WIDTH-1:0]          cfg_base_i,
  input  wire  [`RAB_ADDR_WIDTH-1:0]          cfg_end_i,
  input  wire  [`RAB_ADDR_WIDTH-1:0]          cfg_phys_i,
  input  wire                                 cfg_wen_i,
  input  wire  [`RAB_ID_WIDTH-1:0]            s_awid_i,
  input  wire  [`RAB_ADDR_WIDTH-1:0]          s_awaddr_i,
  input  wire  [7:0]                          s_awlen_i,
  input  wire  [`RAB_USER_WIDTH-1:0]          s_awuser_i,
  input  wire                                 s_awvalid_i,
  output logic                                s_awready_o,
  input  wire  [`RAB_DATA_WIDTH-1:0]          s_wdata_i,
  input  wire                                 s_wlast_i,
  input  wire                                 s_wvalid_i,
  output logic                                s_wready_o,
  output logic [`RAB_ID_WIDTH-1:0]            s_bid_o,
  output logic [1:0]                          s_bresp_o,
  output logic [`RAB_USER_WIDTH-1:0]          s_buser_o,
  output logic                                s_bvalid_o,
  input  wire                                 s_bready_i,
  output logic [`RAB_ID_WIDTH-1:0]            m_awid_o,
  output logic [`RAB_ADDR_WIDTH-1:0]          m_awaddr_o,
  output logic [7:0]                          m_awlen_o,
  output logic                                m_awvalid_o,
  input  wire                                 m_awready_i,
  output logic [`RAB_DATA_WIDTH-1:0]          m_wdata_o,
  output logic                                m_wlast_o,
  output logic                                m_wvalid_o,
  input  wire                                 m_wready_i,
  input  wire  [`RAB_ID_WIDTH-1:0]            m_bid_i,
  input  wire  [1:0]                          m_bresp_i,
  input  wire  [`RAB_USER_WIDTH-1:0]          m_buser_i,
  input  wire                                 m_bvalid_i,
  output logic                                m_bready_o
);

  import rab_pkg::*;

  drop_meta_t dec_in;
  logic       dec_in_valid;
  logic       dec_in_ready;
  drop_meta_t dec_head;
  logic       dec_head_valid;
  logic       dec_head_ready;
  drop_meta_t drop_meta;
  logic       drop_valid;
  logic       drop_ready;

  aw_check u_aw_check (
    .axi4_aclk   (axi4_aclk),
    .axi4_arstn  (axi4_arstn),
    .cfg_we_i    (cfg_we_i),
    .cfg_idx_i   (cfg_idx_i),
    .cfg_base_i  (cfg_base_i),
    .cfg_end_i   (cfg_end_i),
    .cfg_phys_i  (cfg_phys_i),
    .cfg_wen_i   (cfg_wen_i),
    .s_awid_i    (s_awid_i),
    .s_awaddr_i  (s_awaddr_i),
    .s_awlen_i   (s_awlen_i),
    .s_awuser_i  (s_awuser_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .m_awid_o    (m_awid_o),
    .m_awaddr_o  (m_awaddr_o),
    .m_awlen_o   (m_awlen_o),
    .m_awvalid_o (m_awvalid_o),
    .m_awready_i (m_awready_i),
    .dec_o       (dec_in),
    .dec_valid_o (dec_in_valid),
    .dec_ready_i (dec_in_ready)
  );

  // one entry per accepted AW, in burst order, popped by the W filter
  meta_fifo #(
    .WIDTH ($bits(drop_meta_t))
  ) u_dec_fifo (
    .axi4_aclk   (axi4_aclk),
    .axi4_arstn  (axi4_arstn),
    .in_data_i   (dec_in),
    .in_valid_i  (dec_in_valid),
    .in_ready_o  (dec_in_ready),
    .out_data_o  (dec_head),
    .out_valid_o (dec_head_valid),
    .out_ready_i (dec_head_ready)
  );

  w_filter u_w_filter (
    .axi4_aclk    (axi4_aclk),
    .axi4_arstn   (axi4_arstn),
    .s_wdata_i    (s_wdata_i),
    .s_wlast_i    (s_wlast_i),
    .s_wvalid_i   (s_wvalid_i),
    .s_wready_o   (s_wready_o),
    .m_wdata_o    (m_wdata_o),
    .m_wlast_o    (m_wlast_o),
    .m_wvalid_o   (m_wvalid_o),
    .m_wready_i   (m_wready_i),
    .dec_i        (dec_head),
    .dec_valid_i  (dec_head_valid),
    .dec_ready_o  (dec_head_ready),
    .drop_o       (drop_meta),
    .drop_valid_o (drop_valid),
    .drop_ready_i (drop_ready)
  );

  b_send u_b_send (
    .axi4_aclk    (axi4_aclk),
    .axi4_arstn   (axi4_arstn),
    .drop_i       (drop_meta),
    .drop_valid_i (drop_valid),
    .drop_ready_o (drop_ready),
    .s_bid_o      (s_bid_o),
    .s_bresp_o    (s_bresp_o),
    .s_buser_o    (s_buser_o),
    .s_bvalid_o   (s_bvalid_o),
    .s_bready_i   (s_bready_i),
    .m_bid_i      (m_bid_i),
    .m_bresp_i    (m_bresp_i),
    .m_buser_i    (m_buser_i),
    .m_bvalid_i   (m_bvalid_i),
    .m_bready_o   (m_bready_o)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the RAB write path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_rab_write_path -f all.f \
  --Mdir obj_dir -o tb_rab_write_path
./obj_dir/tb_rab_write_path > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
grep -q "TEST RESULT: PASS" sim.log

// ==== sim/rab_write_tests.txt ====
// region line: 1 idx base end phys write_enable 0 0
// burst line: 2 id addr len prefetch forwarded resp phys (phys 0 when dropped), 0 ends the list
1 0 00001000 00001fff 80000000 1 0 0
1 1 00002000 00002fff 90000000 0 0 0
1 2 00010000 0001ffff a0000000 1 0 0
1 3 ffffffff 00000000 00000000 0 0 0
2 1 00001040 3 0 1 0 80000040
2 2 00002010 1 0 0 2 00000000
2 3 00005000 0 0 0 2 00000000
2 4 00001100 0 1 0 0 00000000
2 5 00007000 2 1 0 2 00000000
2 6 00010200 7 0 1 0 a0000200
2 7 00002ff0 2 0 0 2 00000000
2 8 00001ffc 0 0 1 0 80000ffc
2 9 00018000 4 0 1 0 a0008000
2 a 00003000 1 0 0 2 00000000
2 b 00002000 0 1 0 0 00000000
1 1 00002000 00002fff b0000000 1 0 0
1 3 00005000 00005fff c0000000 1 0 0
2 1 00002010 1 0 1 0 b0000010
2 2 00005000 0 0 1 0 c0000000
2 3 00001040 3 0 1 0 80000040
2 4 00005800 1 1 0 0 00000000
1 0 00001000 00001fff 80000000 0 0 0
2 5 00001040 3 0 0 2 00000000
2 6 00010000 1 0 1 0 a0000000
2 7 00001800 0 1 0 0 00000000
0 0 00000000 0 0 0 0 00000000

// ==== sim/tb_clock.sv ====
// **************************************************************************
// clock and reset for the RAB write path testbench
// 20 ns clock; reset is held low for 8 cycles, then released on a
// falling edge
// **************************************************************************
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
  parameter int HALF_PERIOD_NS = 10,
  parameter int RESET_CYCLES   = 8
) (
  output logic clk_o,
  output logic rstn_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  initial begin
    rstn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rstn_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== sim/tb_rab_write_path.sv ====
// **************************************************************************
// testbench of the RAB write path
// region entries and bursts come from sim/rab_write_tests.txt; a memory
// model answers forwarded writes, and an LFSR lowers the ready inputs
// responses are matched by ID, forwarded traffic against the file
// **************************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "rab_settings.svh"

module tb_rab_write_path;

  localparam int ID_W      = `RAB_ID_WIDTH;
  localparam int IDX_W     = $clog2(`RAB_NUM_REGIONS);
  localparam int NUM_IDS   = 1 << ID_W;
  localparam int MAX_LINES = 64;
  localparam int MAX_WORDS = MAX_LINES * 8;

  typedef struct packed {
    logic [ID_W-1:0]            id;
    logic [`RAB_ADDR_WIDTH-1:0] addr;
    logic [7:0]                 len;
  } aw_exp_t;

  logic axi4_aclk;
  logic axi4_arstn;

  logic                        cfg_we;
  logic [IDX_W-1:0]            cfg_idx;
  logic [`RAB_ADDR_WIDTH-1:0]  cfg_base;
  logic [`RAB_ADDR_WIDTH-1:0]  cfg_end;
  logic [`RAB_ADDR_WIDTH-1:0]  cfg_phys;
  logic                        cfg_wen;
  logic [ID_W-1:0]             s_awid;
  logic [`RAB_ADDR_WIDTH-1:0]  s_awaddr;
  logic [7:0]                  s_awlen;
  logic [`RAB_USER_WIDTH-1:0]  s_awuser;
  logic                        s_awvalid;
  logic                        s_awready_o;
  logic [`RAB_DATA_WIDTH-1:0]  s_wdata;
  logic                        s_wlast;
  logic                        s_wvalid;
  logic                        s_wready_o;
  logic [ID_W-1:0]             s_bid_o;
  logic [1:0]                  s_bresp_o;
  logic [`RAB_USER_WIDTH-1:0]  s_buser_o;
  logic                        s_bvalid_o;
  logic                        s_bready  = 1'b0;
  logic [ID_W-1:0]             m_awid_o;
  logic [`RAB_ADDR_WIDTH-1:0]  m_awaddr_o;
  logic [7:0]                  m_awlen_o;
  logic                        m_awvalid_o;
  logic                        m_awready = 1'b0;
  logic [`RAB_DATA_WIDTH-1:0]  m_wdata_o;
  logic                        m_wlast_o;
  logic                        m_wvalid_o;
  logic                        m_wready  = 1'b0;
  logic [ID_W-1:0]             m_bid     = '0;
  logic [1:0]                  m_bresp   = 2'b00;
  logic [`RAB_USER_WIDTH-1:0]  m_buser   = '0;
  logic                        m_bvalid  = 1'b0;
  logic                        m_bready_o;

  logic [31:0]     tests [0:MAX_WORDS-1];
  aw_exp_t         fwd_exp [0:MAX_LINES-1];
  aw_exp_t         w_jobs [0:MAX_LINES-1];
  aw_exp_t         w_job;
  aw_exp_t         aw_seen;
  aw_exp_t         mem_aw_q [$];
  logic [ID_W-1:0] bq [$];
  logic [1:0]      exp_resp [NUM_IDS];
  logic            exp_fwd [NUM_IDS];
  int              issued_cnt [NUM_IDS];
  int              answered_cnt [NUM_IDS];
  int              issued_total   = 0;
  int              answered_total = 0;
  int              fwd_wr = 0;
  int              fwd_rd = 0;
  int              w_wr   = 0;
  int              w_rd   = 0;
  int              exp_w_beats = 0;
  int              m_w_beats   = 0;
  logic [7:0]      w_beat      = '0;
  int              n_bursts    = 0;
  int              checks      = 0;
  int              errors      = 0;
  int              cycles      = 0;
  int              limit       = 1000000;
  logic            stim_done   = 1'b0;
  logic            checks_done = 1'b0;
  logic [31:0]     lfsr_state  = 32'h096e705f;

  tb_clock u_clock (
    .clk_o  (axi4_aclk),
    .rstn_o (axi4_arstn)
  );

  rab_write_path dut0 (
    .axi4_aclk   (axi4_aclk),
    .axi4_arstn  (axi4_arstn),
    .cfg_we_i    (cfg_we),
    .cfg_idx_i   (cfg_idx),
    .cfg_base_i  (cfg_base),
    .cfg_end_i   (cfg_end),
    .cfg_phys_i  (cfg_phys),
    .cfg_wen_i   (cfg_wen),
    .s_awid_i    (s_awid),
    .s_awaddr_i  (s_awaddr),
    .s_awlen_i   (s_awlen),
    .s_awuser_i  (s_awuser),
    .s_awvalid_i (s_awvalid),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata),
    .s_wlast_i   (s_wlast),
    .s_wvalid_i  (s_wvalid),
    .s_wready_o  (s_wready_o),
    .s_bid_o     (s_bid_o),
    .s_bresp_o   (s_bresp_o),
    .s_buser_o   (s_buser_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready),
    .m_awid_o    (m_awid_o),
    .m_awaddr_o  (m_awaddr_o),
    .m_awlen_o   (m_awlen_o),
    .m_awvalid_o (m_awvalid_o),
    .m_awready_i (m_awready),
    .m_wdata_o   (m_wdata_o),
    .m_wlast_o   (m_wlast_o),
    .m_wvalid_o  (m_wvalid_o),
    .m_wready_i  (m_wready),
    .m_bid_i     (m_bid),
    .m_bresp_i   (m_bresp),
    .m_buser_i   (m_buser),
    .m_bvalid_i  (m_bvalid),
    .m_bready_o  (m_bready_o)
  );

  // the feedback uses taps 32, 22, 2 and 1 and enters at the bottom
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // ready is low only when both drawn bits are zero
  task automatic draw_ready(output logic rdy);
    logic first;
    lfsr_state = lfsr_next(lfsr_state);
    first = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
    rdy = first | lfsr_state[0];
  endtask

  function automatic logic [31:0] beat_data(input logic [ID_W-1:0] id, input logic [7:0] beat);
    return {8'hd5, 12'h000, id, beat};
  endfunction

  // the memory model tags each of its responses with a nonzero user value made from the ID
  function automatic logic [`RAB_USER_WIDTH-1:0] mem_buser(input logic [ID_W-1:0] id);
    return {1'b1, id[0]};
  endfunction

  task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // a region is only rewritten once every earlier burst has its response
  task automatic write_region(input int pos);
    while (answered_total != issued_total) @(negedge axi4_aclk);
    cfg_idx  = tests[pos+1][IDX_W-1:0];
    cfg_base = tests[pos+2];
    cfg_end  = tests[pos+3];
    cfg_phys = tests[pos+4];
    cfg_wen  = tests[pos+5][0];
    cfg_we   = 1'b1;
    @(negedge axi4_aclk);
    cfg_we = 1'b0;
  endtask

  task automatic issue_burst(input int pos);
    aw_exp_t job;
    job.id   = tests[pos+1][ID_W-1:0];
    job.addr = tests[pos+7];
    job.len  = tests[pos+3][7:0];
    while (issued_cnt[job.id] != answered_cnt[job.id]) @(negedge axi4_aclk);
    exp_resp[job.id] = tests[pos+6][1:0];
    exp_fwd[job.id]  = tests[pos+5][0];
    issued_cnt[job.id]++;
    issued_total++;
    if (tests[pos+5][0]) begin
      fwd_exp[fwd_wr] = job;
      fwd_wr++;
      exp_w_beats += int'(job.len) + 1;
    end
    w_jobs[w_wr] = job;
    w_wr++;
    s_awid      = job.id;
    s_awaddr    = tests[pos+2];
    s_awlen     = job.len;
    s_awuser    = '0;
    s_awuser[0] = tests[pos+4][0];
    s_awvalid   = 1'b1;
    @(posedge axi4_aclk);
    while (!s_awready_o) @(posedge axi4_aclk);
    @(negedge axi4_aclk);
    s_awvalid = 1'b0;
  endtask

  initial begin : stimulus
    int pos;
    cfg_we    = 1'b0;
    cfg_idx   = '0;
    cfg_base  = '0;
    cfg_end   = '0;
    cfg_phys  = '0;
    cfg_wen   = 1'b0;
    s_awid    = '0;
    s_awaddr  = '0;
    s_awlen   = '0;
    s_awuser  = '0;
    s_awvalid = 1'b0;
    for (int i = 0; i < NUM_IDS; i++) begin
      issued_cnt[i]   = 0;
      answered_cnt[i] = 0;
      exp_resp[i]     = 2'b00;
      exp_fwd[i]      = 1'b0;
    end
    $readmemh("sim/rab_write_tests.txt", tests);
    for (int i = 0; i < MAX_LINES; i++) begin
      if (tests[i*8] === 32'd2) begin
        n_bursts++;
      end else if (tests[i*8] !== 32'd1) begin
        break;
      end
    end
    limit = 200 * n_bursts + 100;
    wait (axi4_arstn === 1'b1);
    @(negedge axi4_aclk);
    for (int i = 0; i < MAX_LINES; i++) begin
      pos = i * 8;
      if (tests[pos] === 32'd1) begin
        write_region(pos);
      end else if (tests[pos] === 32'd2) begin
        issue_burst(pos);
      end else begin
        break;
      end
    end
    stim_done = 1'b1;
    while (!checks_done) @(negedge axi4_aclk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // W beats of each issued burst, in issue order
  initial begin : w_driver
    s_wdata  = '0;
    s_wlast  = 1'b0;
    s_wvalid = 1'b0;
    wait (axi4_arstn === 1'b1);
    forever begin
      @(negedge axi4_aclk);
      if (w_rd < w_wr) begin
        w_job = w_jobs[w_rd];
        w_rd++;
        for (int k = 0; k <= int'(w_job.len); k++) begin
          s_wdata  = beat_data(w_job.id, 8'(k));
          s_wlast  = (k == int'(w_job.len));
          s_wvalid = 1'b1;
          @(posedge axi4_aclk);
          while (!s_wready_o) @(posedge axi4_aclk);
          @(negedge axi4_aclk);
        end
        s_wvalid = 1'b0;
        s_wlast  = 1'b0;
      end
    end
  end

  // random readies and the B channel of the memory model
  always @(negedge axi4_aclk) begin
    draw_ready(m_awready);
    draw_ready(m_wready);
    draw_ready(s_bready);
    m_bvalid = (bq.size() != 0);
    if (bq.size() != 0) begin
      m_bid   = bq[0];
      m_buser = mem_buser(bq[0]);
    end
  end

  // memory model and response checks, sampled on the rising edge
  always @(posedge axi4_aclk) begin
    if (axi4_arstn) begin
      if (m_awvalid_o && m_awready) begin
        checks++;
        assert (fwd_rd < fwd_wr) else begin
          errors++;
          $display("at %0t ns burst ID %0h reached m_aw although it should have been dropped",
                   $time, m_awid_o);
        end
        if (fwd_rd < fwd_wr) begin
          compare_value(32'(m_awid_o), 32'(fwd_exp[fwd_rd].id), "m_awid");
          compare_value(m_awaddr_o, fwd_exp[fwd_rd].addr, "m_awaddr");
          compare_value(32'(m_awlen_o), 32'(fwd_exp[fwd_rd].len), "m_awlen");
          fwd_rd++;
        end
        aw_seen.id   = m_awid_o;
        aw_seen.addr = m_awaddr_o;
        aw_seen.len  = m_awlen_o;
        mem_aw_q.push_back(aw_seen);
      end
      if (m_bvalid && m_bready_o) begin
        void'(bq.pop_front());
      end
      if (m_wvalid_o && m_wready) begin
        checks++;
        assert (mem_aw_q.size() != 0) else begin
          errors++;
          $display("at %0t ns a beat appeared on m_w before the m_aw of its burst", $time);
        end
        if (mem_aw_q.size() != 0) begin
          compare_value(m_wdata_o, beat_data(mem_aw_q[0].id, w_beat), "m_wdata");
          compare_value(32'(m_wlast_o), 32'(w_beat == mem_aw_q[0].len), "m_wlast");
          if (m_wlast_o) begin
            // the memory answers OKAY with the burst's own ID
            bq.push_back(mem_aw_q[0].id);
            void'(mem_aw_q.pop_front());
            w_beat = '0;
          end else begin
            w_beat++;
          end
        end
        m_w_beats++;
      end
      if (s_bvalid_o && s_bready) begin
        checks++;
        assert (issued_cnt[s_bid_o] != answered_cnt[s_bid_o]) else begin
          errors++;
          $display("at %0t ns a response came for ID %0h, which has no write outstanding",
                   $time, s_bid_o);
        end
        compare_value(32'(s_bresp_o), 32'(exp_resp[s_bid_o]), "s_bresp");
        if (exp_fwd[s_bid_o]) begin
          compare_value(32'(s_buser_o), 32'(mem_buser(s_bid_o)), "s_buser");
        end else begin
          compare_value(32'(s_buser_o), 32'd0, "s_buser");
        end
        answered_cnt[s_bid_o]++;
        answered_total++;
      end
      if (stim_done && !checks_done && answered_total == issued_total) begin
        compare_value(m_w_beats, exp_w_beats, "m_w beat count");
        checks++;
        assert (fwd_rd == fwd_wr) else begin
          errors++;
          $display("%0d forwarded bursts never appeared on m_aw", fwd_wr - fwd_rd);
        end
        checks_done = 1'b1;
      end
    end
  end

  always @(posedge axi4_aclk) begin
    cycles++;
    if (cycles >= limit) begin
      $display("timeout after %0d cycles with %0d of %0d writes answered, errors: %0d",
               cycles, answered_total, issued_total, errors);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== w_filter/w_filter.sv ====
// **************************************************************************
// W side of the RAB: routes write beats by the decision at the FIFO head
// forwarded bursts go straight through to m_w, dropped bursts are taken
// from the master and thrown away; each finished dropped burst is then
// reported to the B sender before its decision is popped
// **************************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "rab_settings.svh"

module w_filter (
  input  wire                        axi4_aclk,
  input  wire                        axi4_arstn,
  input  wire  [`RAB_DATA_WIDTH-1:0] s_wdata_i,
  input  wire                        s_wlast_i,
  input  wire                        s_wvalid_i,
  output logic                       s_wready_o,
  output logic [`RAB_DATA_WIDTH-1:0] m_wdata_o,
  output logic                       m_wlast_o,
  output logic                       m_wvalid_o,
  input  wire                        m_wready_i,
  input  wire  rab_pkg::drop_meta_t  dec_i,
  input  wire                        dec_valid_i,
  output logic                       dec_ready_o,
  output rab_pkg::drop_meta_t        drop_o,
  output logic                       drop_valid_o,
  input  wire                        drop_ready_i
);

  import rab_pkg::*;

  typedef enum logic {
    ST_BEATS,
    ST_REPORT
  } state_e;

  state_e state;
  logic   fwd;
  logic   dis;
  logic   last_beat;

  // fwd and dis are only set while a decision is waiting and beats may move
  assign fwd = (state == ST_BEATS) & dec_valid_i & ~dec_i.drop;
  assign dis = (state == ST_BEATS) & dec_valid_i & dec_i.drop;

  assign m_wdata_o  = s_wdata_i;
  assign m_wlast_o  = s_wlast_i;
  assign m_wvalid_o = fwd & s_wvalid_i;
  assign s_wready_o = (fwd & m_wready_i) | dis;

  assign last_beat = s_wvalid_i & s_wready_o & s_wlast_i;

  assign drop_o       = dec_i;
  assign drop_valid_o = (state == ST_REPORT);

  always_comb begin
    dec_ready_o = 1'b0;
    if (fwd && last_beat) begin
      dec_ready_o = 1'b1;
    end else if (drop_valid_o && drop_ready_i) begin
      // once the report is taken the decision can go
      dec_ready_o = 1'b1;
    end
  end

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      state <= ST_BEATS;
    end else begin
      case (state)
        ST_BEATS: begin
          if (dis && last_beat) begin
            state <= ST_REPORT;
          end
        end
        ST_REPORT: begin
          if (drop_ready_i) begin
            state <= ST_BEATS;
          end
        end
        default: state <= ST_BEATS;
      endcase
    end
  end

endmodule

`default_nettype wire
